// ==== rv_pkg.sv ====
package rv_pkg;

  // RV32 register and instruction width
  parameter int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // major opcodes kept by this core
  // any other encoding decodes as illegal
  typedef enum logic [6:0] {
    op_lui = 7'b0110111,
    op_imm = 7'b0010011,
    op_reg = 7'b0110011
  } opcode_e;

  // alu function picked in decode
  typedef enum logic [1:0] {
    alu_add      = 2'd0,
    alu_sub      = 2'd1,
    alu_slt      = 2'd2,
    alu_pass_imm = 2'd3
  } alu_op_e;

  // raw word on the input stream
  typedef struct packed {
    word_t insn;
  } fetch_t;

  // decode output, also the queue entry
  typedef struct packed {
    word_t     pc;
    word_t     insn;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    // sign-extended I or U immediate
    word_t     imm;
    alu_op_e   alu_op;
    // immediate replaces rs2 as operand b
    logic      use_imm;
    logic      writes_rd;
    logic      illegal;
  } decoded_t;

  // one record per retired instruction
  typedef struct packed {
    word_t     pc;
    word_t     insn;
    reg_addr_t rd;
    word_t     rd_data;
    logic      writes_rd;
    logic      illegal;
  } wb_trace_t;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  output rv_pkg::word_t     rs1_data,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data
);
  import rv_pkg::*;

  localparam int num_regs = 32;

  word_t regs [num_regs];

  // x0 hardwired to zero on both ports
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      // writes to x0 dropped
      regs[rd] <= rd_data;
    end
  end

endmodule

// ==== insn_decode.sv ====
`timescale 1ns/1ps

module insn_decode #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  output logic             in_ready,
  input  rv_pkg::fetch_t   in_insn,
  output logic             dec_valid,
  input  logic             dec_ready,
  output rv_pkg::decoded_t dec_rec
);
  import rv_pkg::*;

  // funct7 and funct3 codes of the kept ops
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;
  localparam logic [2:0] funct3_add  = 3'b000;
  localparam logic [2:0] funct3_slt  = 3'b010;

  // pc for the next accepted word
  word_t pc_q;
  logic in_fire;
  decoded_t dec_next;

  // instruction fields
  word_t      insn;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i_sext;
  word_t      imm_u;

  assign insn   = in_insn.insn;
  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // I-type, sign bit is insn[31]
  assign imm_i_sext = {{20{insn[31]}}, insn[31:20]};
  // U-type, low 12 bits zero
  assign imm_u = {insn[31:12], 12'b0};

  // room when empty or draining this cycle
  assign in_ready = !dec_valid || dec_ready;
  assign in_fire  = in_valid && in_ready;

  always_comb begin
    dec_next           = '0;
    dec_next.pc        = pc_q;
    dec_next.insn      = insn;
    dec_next.rd        = insn[11:7];
    dec_next.rs1       = insn[19:15];
    dec_next.rs2       = insn[24:20];
    dec_next.imm       = imm_i_sext;
    dec_next.alu_op    = alu_add;
    dec_next.use_imm   = 1'b0;
    dec_next.writes_rd = 1'b0;
    dec_next.illegal   = 1'b0;
    case (opcode)
      op_lui: begin
        dec_next.imm       = imm_u;
        dec_next.alu_op    = alu_pass_imm;
        dec_next.use_imm   = 1'b1;
        dec_next.writes_rd = 1'b1;
      end
      op_imm: begin
        dec_next.use_imm = 1'b1;
        if (funct3 == funct3_add) begin
          dec_next.alu_op    = alu_add;
          dec_next.writes_rd = 1'b1;
        end else if (funct3 == funct3_slt) begin
          dec_next.alu_op    = alu_slt;
          dec_next.writes_rd = 1'b1;
        end else begin
          dec_next.illegal = 1'b1;
        end
      end
      op_reg: begin
        // only add and sub, funct7 picks which
        if (funct3 == funct3_add && funct7 == funct7_base) begin
          dec_next.alu_op    = alu_add;
          dec_next.writes_rd = 1'b1;
        end else if (funct3 == funct3_add && funct7 == funct7_alt) begin
          dec_next.alu_op    = alu_sub;
          dec_next.writes_rd = 1'b1;
        end else begin
          dec_next.illegal = 1'b1;
        end
      end
      default: begin
        dec_next.illegal = 1'b1;
      end
    endcase
  end

  // valid flag and pc counter
  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
      pc_q      <= reset_pc;
    end else if (in_fire) begin
      dec_valid <= 1'b1;
      pc_q      <= pc_q + 32'd4;
    end else if (dec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  // decoded record, loaded on accept only
  always_ff @(posedge clk) begin
    if (in_fire) begin
      dec_rec <= dec_next;
    end
  end

endmodule

// ==== insn_queue.sv ====
`timescale 1ns/1ps

module insn_queue #(
  parameter int queue_depth = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             dec_valid,
  output logic             dec_ready,
  input  rv_pkg::decoded_t dec_rec,
  output logic             q_valid,
  input  logic             q_ready,
  output rv_pkg::decoded_t q_rec
);
  import rv_pkg::*;

  localparam int ptr_w = $clog2(queue_depth);
  localparam int cnt_w = $clog2(queue_depth + 1);

  decoded_t mem [queue_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic full;
  logic wr_en;
  logic rd_en;

  assign full    = count == cnt_w'(queue_depth);
  assign q_valid = count != '0;
  assign q_rec   = mem[rd_ptr];
  // full queue still takes a word if the head leaves on the same edge
  assign dec_ready = !full || q_ready;
  assign wr_en     = dec_valid && dec_ready;
  assign rd_en     = q_valid && q_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at the last entry
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= dec_rec;
    end
  end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              q_valid,
  output logic              q_ready,
  input  rv_pkg::decoded_t  q_rec,
  output logic              trace_valid,
  input  logic              trace_ready,
  output rv_pkg::wb_trace_t trace
);
  import rv_pkg::*;

  // writeback register
  logic      wb_valid;
  wb_trace_t wb_q;
  wb_trace_t wb_next;

  // register file side
  word_t rs1_data;
  word_t rs2_data;
  logic  rf_we;
  logic  trace_fire;
  logic  head_fire;

  // operands after bypass
  logic  fwd_ok;
  word_t op_a;
  word_t op_b_reg;
  word_t op_b;

  // adder shared by add and sub
  logic  is_sub;
  word_t add_b;
  word_t sum;
  word_t alu_result;

  assign trace_valid = wb_valid;
  assign trace       = wb_q;
  assign trace_fire  = trace_valid && trace_ready;

  // head moves when wb is empty or leaving now
  assign q_ready   = !wb_valid || trace_ready;
  assign head_fire = q_valid && q_ready;

  // commit on the trace transfer
  assign rf_we = trace_fire && wb_q.writes_rd && !wb_q.illegal;

  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (q_rec.rs1),
    .rs1_data (rs1_data),
    .rs2      (q_rec.rs2),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (wb_q.rd),
    .rd_data  (wb_q.rd_data)
  );

  // wb result not yet in the file so bypass it
  assign fwd_ok   = wb_valid && wb_q.writes_rd && !wb_q.illegal && wb_q.rd != '0;
  assign op_a     = (fwd_ok && wb_q.rd == q_rec.rs1) ? wb_q.rd_data : rs1_data;
  assign op_b_reg = (fwd_ok && wb_q.rd == q_rec.rs2) ? wb_q.rd_data : rs2_data;
  assign op_b     = q_rec.use_imm ? q_rec.imm : op_b_reg;

  // sub is a + ~b + 1
  assign is_sub = q_rec.alu_op == alu_sub;
  assign add_b  = is_sub ? ~op_b : op_b;
  assign sum    = op_a + add_b + word_t'(is_sub);

  always_comb begin
    case (q_rec.alu_op)
      alu_add, alu_sub: alu_result = sum;
      alu_slt:          alu_result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
      // lui takes the imm already shifted in decode
      alu_pass_imm:     alu_result = q_rec.imm;
      default:          alu_result = '0;
    endcase
  end

  always_comb begin
    wb_next.pc        = q_rec.pc;
    wb_next.insn      = q_rec.insn;
    wb_next.rd        = q_rec.rd;
    // illegal records carry zero data
    wb_next.rd_data   = q_rec.illegal ? '0 : alu_result;
    wb_next.writes_rd = q_rec.writes_rd;
    wb_next.illegal   = q_rec.illegal;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (head_fire) begin
      wb_valid <= 1'b1;
    end else if (trace_fire) begin
      wb_valid <= 1'b0;
    end
  end

  // payload held until the trace is taken
  always_ff @(posedge clk) begin
    if (head_fire) begin
      wb_q <= wb_next;
    end
  end

endmodule

// ==== riscv_pipe_core.sv ====
`timescale 1ns/1ps

module riscv_pipe_core #(
  parameter rv_pkg::word_t reset_pc    = '0,
  parameter int            queue_depth = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  output logic              in_ready,
  input  rv_pkg::fetch_t    in_insn,
  output logic              trace_valid,
  input  logic              trace_ready,
  output rv_pkg::wb_trace_t trace
);
  import rv_pkg::*;

  // decode to queue
  logic     dec_valid;
  logic     dec_ready;
  decoded_t dec_rec;

  // queue to execute
  logic     q_valid;
  logic     q_ready;
  decoded_t q_rec;

  insn_decode #(
    .reset_pc (reset_pc)
  ) insn_decode_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_insn   (in_insn),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_rec   (dec_rec)
  );

  insn_queue #(
    .queue_depth (queue_depth)
  ) insn_queue_inst (
    .clk       (clk),
    .rst       (rst),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_rec   (dec_rec),
    .q_valid   (q_valid),
    .q_ready   (q_ready),
    .q_rec     (q_rec)
  );

  execute_stage execute_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .q_valid     (q_valid),
    .q_ready     (q_ready),
    .q_rec       (q_rec),
    .trace_valid (trace_valid),
    .trace_ready (trace_ready),
    .trace       (trace)
  );

endmodule

// ==== riscv_pipe_core_asserts.sv ====
`timescale 1ns/1ps

module riscv_pipe_core_asserts (
  input logic              clk,
  input logic              rst,
  input logic              in_valid,
  input logic              in_ready,
  input rv_pkg::fetch_t    in_insn,
  input logic              trace_valid,
  input logic              trace_ready,
  input rv_pkg::wb_trace_t trace
);

  // failed assertions so far
  int fail_count;

  initial begin
    fail_count = 0;
  end

  // stalled input word stays on the bus unchanged
  in_hold_a: assert property (@(posedge clk) disable iff (rst)
    in_valid && !in_ready |=> in_valid && $stable(in_insn))
    else begin
      $error("input word dropped or changed while stalled");
      fail_count++;
    end

  // stalled trace record stays put
  trace_hold_a: assert property (@(posedge clk) disable iff (rst)
    trace_valid && !trace_ready |=> trace_valid && $stable(trace))
    else begin
      $error("trace record dropped or changed while stalled");
      fail_count++;
    end

  // nothing retires straight out of reset
  reset_idle_a: assert property (@(posedge clk)
    rst |=> !trace_valid)
    else begin
      $error("trace valid right after reset");
      fail_count++;
    end

  // illegal encodings never claim a register write
  illegal_no_write_a: assert property (@(posedge clk) disable iff (rst)
    trace_valid |-> !(trace.illegal && trace.writes_rd))
    else begin
      $error("illegal record marked as writing rd");
      fail_count++;
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period       = 4,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst
);

  // free-running clock, half period high
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset held for a fixed number of edges, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== riscv_pipe_core_tb.sv ====
`timescale 1ns/1ps

module riscv_pipe_core_tb;
  import rv_pkg::*;

  localparam word_t reset_pc        = 32'h0000_0100;
  localparam int    queue_depth     = 4;
  localparam int    num_rows        = 21;
  localparam int    clk_period      = 4;
  localparam int    drain_cycles    = 20;
  // worst case random stalls on both sides plus reset and drain
  localparam int    watchdog_cycles = num_rows * 20 + 100;

  // one table entry with the word in and the expected writeback out
  typedef struct packed {
    logic [31:0] insn;
    logic [4:0]  rd;
    logic [31:0] rd_data;
    logic        illegal;
  } row_t;

  logic      clk;
  logic      rst;
  logic      in_valid;
  logic      in_ready;
  fetch_t    in_insn;
  logic      trace_valid;
  logic      trace_ready;
  wb_trace_t trace;

  row_t   rows [num_rows];
  integer seed;
  int     sent;
  int     received;
  int     err_count;
  int     row_errs;
  int     rows_failed;
  int     assert_fails;

  tb_clk_gen #(
    .period       (clk_period),
    .reset_cycles (2)
  ) tb_clk_gen_inst (
    .clk (clk),
    .rst (rst)
  );

  riscv_pipe_core #(
    .reset_pc    (reset_pc),
    .queue_depth (queue_depth)
  ) riscv_pipe_core_inst (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_insn     (in_insn),
    .trace_valid (trace_valid),
    .trace_ready (trace_ready),
    .trace       (trace)
  );

  bind riscv_pipe_core riscv_pipe_core_asserts riscv_pipe_core_asserts_inst (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_insn     (in_insn),
    .trace_valid (trace_valid),
    .trace_ready (trace_ready),
    .trace       (trace)
  );

  // expected values worked from the all-zero register state
  task automatic load_table();
    rows[0]  = '{32'h123450B7, 5'd1,  32'h12345000, 1'b0}; // lui  x1, 0x12345
    rows[1]  = '{32'h67808093, 5'd1,  32'h12345678, 1'b0}; // addi x1, x1, 0x678
    rows[2]  = '{32'hFFF00113, 5'd2,  32'hFFFFFFFF, 1'b0}; // addi x2, x0, -1
    rows[3]  = '{32'h00500193, 5'd3,  32'h00000005, 1'b0}; // addi x3, x0, 5
    rows[4]  = '{32'h00308233, 5'd4,  32'h1234567D, 1'b0}; // add  x4, x1, x3
    rows[5]  = '{32'h403202B3, 5'd5,  32'h12345678, 1'b0}; // sub  x5, x4, x3
    rows[6]  = '{32'h40218333, 5'd6,  32'h00000006, 1'b0}; // sub  x6, x3, x2
    rows[7]  = '{32'h00112393, 5'd7,  32'h00000001, 1'b0}; // slti x7, x2, 1
    rows[8]  = '{32'hFFF1A413, 5'd8,  32'h00000000, 1'b0}; // slti x8, x3, -1
    rows[9]  = '{32'h00708013, 5'd0,  32'h1234567F, 1'b0}; // addi x0, x1, 7
    rows[10] = '{32'h000004B3, 5'd9,  32'h00000000, 1'b0}; // add  x9, x0, x0
    rows[11] = '{32'h0000008B, 5'd1,  32'h00000000, 1'b1}; // custom-0 opcode
    rows[12] = '{32'h00008593, 5'd11, 32'h12345678, 1'b0}; // addi x11, x1, 0
    rows[13] = '{32'h001090B3, 5'd1,  32'h00000000, 1'b1}; // sll is not kept
    rows[14] = '{32'h00008633, 5'd12, 32'h12345678, 1'b0}; // add  x12, x1, x0
    rows[15] = '{32'hFFFFF6B7, 5'd13, 32'hFFFFF000, 1'b0}; // lui  x13, 0xfffff
    rows[16] = '{32'hFF068693, 5'd13, 32'hFFFFEFF0, 1'b0}; // addi x13, x13, -16
    rows[17] = '{32'h0006A713, 5'd14, 32'h00000001, 1'b0}; // slti x14, x13, 0
    rows[18] = '{32'h00E687B3, 5'd15, 32'hFFFFEFF1, 1'b0}; // add  x15, x13, x14
    rows[19] = '{32'h40D78833, 5'd16, 32'h00000001, 1'b0}; // sub  x16, x15, x13
    rows[20] = '{32'h8000A893, 5'd17, 32'h00000000, 1'b0}; // slti x17, x1, -2048
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      err_count++;
      row_errs++;
    end
  endtask

  // compare the record on the bus with table row idx
  task automatic check_record(input int idx);
    row_errs = 0;
    check_field("trace.pc", trace.pc, reset_pc + 32'(idx * 4));
    check_field("trace.insn", trace.insn, rows[idx].insn);
    check_field("trace.rd", 32'(trace.rd), 32'(rows[idx].rd));
    check_field("trace.rd_data", trace.rd_data, rows[idx].rd_data);
    check_field("trace.illegal", 32'(trace.illegal), 32'(rows[idx].illegal));
    // all five kept ops write rd and illegal ones never do
    check_field("trace.writes_rd", 32'(trace.writes_rd), 32'(!rows[idx].illegal));
    if (row_errs != 0) begin
      rows_failed++;
    end
    $display("row %2d  pc %h  insn %h  x%0d = %h  %s", idx, trace.pc, trace.insn,
             trace.rd, trace.rd_data, (row_errs == 0) ? "ok" : "mismatch");
  endtask

  // stimulus with input gaps and trace back-pressure
  initial begin
    seed        = 28;
    sent        = 0;
    in_valid    = 1'b0;
    in_insn     = '0;
    trace_ready = 1'b0;
    load_table();
    @(posedge clk);
    while (rst) begin
      @(posedge clk);
    end
    forever begin
      @(posedge clk);
      if (in_valid && in_ready) begin
        sent++;
      end
      // bus may change only when idle or just taken
      if (!in_valid || in_ready) begin
        if (sent < num_rows && ($random(seed) & 3) != 0) begin
          in_valid <= 1'b1;
          in_insn  <= '{insn: rows[sent].insn};
        end else begin
          in_valid <= 1'b0;
        end
      end
      // ready about three cycles in four
      trace_ready <= ($random(seed) & 3) != 0;
    end
  end

  // checker on the trace side
  initial begin
    err_count    = 0;
    row_errs     = 0;
    rows_failed  = 0;
    received     = 0;
    assert_fails = 0;
    @(posedge clk);
    while (rst) begin
      @(posedge clk);
    end
    // first cycle out of reset
    check_field("trace_valid", 32'(trace_valid), 32'd0);
    check_field("in_ready", 32'(in_ready), 32'd1);
    while (received < num_rows) begin
      @(posedge clk);
      if (trace_valid && trace_ready) begin
        check_record(received);
        received++;
      end
    end
    // nothing extra may come out
    repeat (drain_cycles) begin
      @(posedge clk);
      assert (!trace_valid) else begin
        $display("extra trace record appeared after the last table row at %0t ns", $time);
        err_count++;
      end
    end
    assert_fails = riscv_pipe_core_inst.riscv_pipe_core_asserts_inst.fail_count;
    $display("%0d rows checked, %0d passed, %0d failed, %0d check errors, %0d assert fails",
             num_rows, num_rows - rows_failed, rows_failed, err_count, assert_fails);
    if (err_count == 0 && assert_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: only %0d of %0d trace records arrived", received, num_rows);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== compile.f ====
rv_pkg.sv
reg_file.sv
insn_decode.sv
insn_queue.sv
execute_stage.sv
riscv_pipe_core.sv
riscv_pipe_core_asserts.sv
tb_clk_gen.sv
riscv_pipe_core_tb.sv

// ==== Makefile ====
TOP = riscv_pipe_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f compile.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
